/* include/frame_params.svh */
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

////////////////////////////////////////
// frame geometry

// pixels per row
`define FRAME_WIDTH 4
// rows per frame
`define FRAME_HEIGHT 3

////////////////////////////////////////
// pair buffer

// 8 entries
`define FIFO_DEPTH_LOG2 3

////////////////////////////////////////
// frame marker, "BIVFRAME", sent msb first
`define FRAME_MAGIC 64'h42_49_56_46_52_41_4D_45
`define MAGIC_BYTES 8

`endif

/* source/frame_pkg.sv */
package frame_pkg;

    ////////////////////////////////////////
    // data widths

    // one channel, one pixel
    typedef logic [7:0] pixel_t;

    // column or row index
    typedef logic [15:0] coord_t;

    // buffer word: [16] frame start tag, [15:8] channel 0, [7:0] channel 1
    typedef logic [16:0] pair_entry_t;

    ////////////////////////////////////////
    // serializer FSM
    typedef enum logic [1:0] {
        SEEK,
        MARKER,
        CH0,
        CH1
    } ser_state_e;

endpackage

/* source/pixel_position_tracker.sv */
`include "frame_params.svh"

module pixel_position_tracker (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  frame_pkg::pixel_t      ch0_i,
    input  frame_pkg::pixel_t      ch1_i,
    input  logic                   pix_valid_i,
    input  logic                   sof_i,
    output frame_pkg::pair_entry_t entry_o,
    output logic                   push_o
);
    localparam frame_pkg::coord_t COL_LAST = frame_pkg::coord_t'(`FRAME_WIDTH - 1);
    localparam frame_pkg::coord_t ROW_LAST = frame_pkg::coord_t'(`FRAME_HEIGHT - 1);

    // position of the next pair to arrive
    frame_pkg::coord_t col;
    frame_pkg::coord_t row;

    // position of the pair on the inputs right now
    frame_pkg::coord_t col_here;
    frame_pkg::coord_t row_here;

    logic synced;
    logic at_origin;

    // sof pulls the current pair back to the origin
    assign col_here  = sof_i ? '0 : col;
    assign row_here  = sof_i ? '0 : row;
    assign at_origin = (col_here == '0) && (row_here == '0);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            col    <= '0;
            row    <= '0;
            synced <= 1'b0;
            push_o <= 1'b0;
        end else begin
            push_o <= pix_valid_i;
            if (pix_valid_i) begin
                // tagging only starts once a real frame start was seen
                if (sof_i) begin
                    synced <= 1'b1;
                end
                if (col_here == COL_LAST) begin
                    col <= '0;
                    row <= (row_here == ROW_LAST) ? '0 : row_here + 1'b1;
                end else begin
                    col <= col_here + 1'b1;
                    row <= row_here;
                end
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (pix_valid_i) begin
            entry_o <= {at_origin && (synced || sof_i), ch0_i, ch1_i};
        end
    end
endmodule

/* source/pair_fifo.sv */
`include "frame_params.svh"

module pair_fifo (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  logic                   push_i,
    input  frame_pkg::pair_entry_t entry_i,
    input  logic                   pop_i,
    output frame_pkg::pair_entry_t head_o,
    output logic                   not_empty_o,
    output logic                   overflow_o
);
    localparam int DEPTH = 1 << `FIFO_DEPTH_LOG2;

    frame_pkg::pair_entry_t mem [DEPTH];

    logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [`FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [`FIFO_DEPTH_LOG2:0]   count;

    logic full;
    logic do_push;
    logic do_pop;

    assign full        = (count == DEPTH[`FIFO_DEPTH_LOG2:0]);
    assign not_empty_o = (count != '0);

    // a pop in the same cycle frees the slot for the push
    assign do_push = push_i && (!full || pop_i);
    assign do_pop  = pop_i && not_empty_o;

    // show-ahead, oldest entry always visible
    assign head_o = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= entry_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
            // sticky until reset
            if (push_i && full && !pop_i) begin
                overflow_o <= 1'b1;
            end
        end
    end
endmodule

/* source/frame_serializer.sv */
`include "frame_params.svh"

module frame_serializer (
    input  logic                   core_clk,
    input  logic                   sys_reset,
    input  frame_pkg::pair_entry_t head_i,
    input  logic                   not_empty_i,
    input  logic                   stall_i,
    output logic                   pop_o,
    output frame_pkg::pixel_t      byte_o,
    output logic                   byte_valid_o
);
    localparam int IDX_W = $clog2(`MAGIC_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`MAGIC_BYTES - 1);
    localparam logic [63:0] MAGIC = `FRAME_MAGIC;

    frame_pkg::ser_state_e state;
    frame_pkg::ser_state_e state_next;

    logic [IDX_W-1:0] byte_idx;
    logic             marker_sent;

    logic              head_tag;
    frame_pkg::pixel_t head_ch0;
    frame_pkg::pixel_t head_ch1;
    frame_pkg::pixel_t marker_byte;

    assign head_tag = head_i[16];
    assign head_ch0 = head_i[15:8];
    assign head_ch1 = head_i[7:0];

    // msb first
    assign marker_byte = MAGIC[8 * (`MAGIC_BYTES - 1 - int'(byte_idx)) +: 8];

    ////////////////////////////////////////
    // next state and outputs
    always_comb begin
        state_next   = state;
        pop_o        = 1'b0;
        byte_valid_o = 1'b0;
        byte_o       = head_ch0;
        if (!stall_i) begin
            case (state)
                frame_pkg::SEEK: begin
                    // drop everything until a frame start shows up
                    if (not_empty_i) begin
                        if (head_tag) begin
                            state_next = frame_pkg::MARKER;
                        end else begin
                            pop_o = 1'b1;
                        end
                    end
                end
                frame_pkg::MARKER: begin
                    byte_valid_o = 1'b1;
                    byte_o       = marker_byte;
                    if (byte_idx == IDX_LAST) begin
                        state_next = frame_pkg::CH0;
                    end
                end
                frame_pkg::CH0: begin
                    // tagged head not yet announced gets its marker first
                    if (not_empty_i) begin
                        if (head_tag && !marker_sent) begin
                            state_next = frame_pkg::MARKER;
                        end else begin
                            byte_valid_o = 1'b1;
                            state_next   = frame_pkg::CH1;
                        end
                    end
                end
                frame_pkg::CH1: begin
                    byte_valid_o = 1'b1;
                    byte_o       = head_ch1;
                    pop_o        = not_empty_i;
                    state_next   = frame_pkg::CH0;
                end
                default: begin
                    state_next = frame_pkg::SEEK;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // state, marker index and marker flag
    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state       <= frame_pkg::SEEK;
            byte_idx    <= '0;
            marker_sent <= 1'b0;
        end else begin
            state <= state_next;
            if (!stall_i && state == frame_pkg::MARKER) begin
                if (byte_idx == IDX_LAST) begin
                    byte_idx    <= '0;
                    marker_sent <= 1'b1;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
            if (pop_o) begin
                marker_sent <= 1'b0;
            end
        end
    end
endmodule

/* source/frame_streamer.sv */
module frame_streamer (
    input  logic              core_clk,
    input  logic              sys_reset,
    input  frame_pkg::pixel_t ch0_i,
    input  frame_pkg::pixel_t ch1_i,
    input  logic              pix_valid_i,
    input  logic              sof_i,
    input  logic              stall_i,
    output frame_pkg::pixel_t byte_o,
    output logic              byte_valid_o,
    output logic              overflow_o
);
    // tracker to buffer
    frame_pkg::pair_entry_t trk_entry;
    logic                   trk_push;

    // buffer to serializer
    frame_pkg::pair_entry_t fifo_head;
    logic                   fifo_not_empty;
    logic                   ser_pop;

    pixel_position_tracker tracker0 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .ch0_i      (ch0_i),
        .ch1_i      (ch1_i),
        .pix_valid_i(pix_valid_i),
        .sof_i      (sof_i),
        .entry_o    (trk_entry),
        .push_o     (trk_push)
    );

    pair_fifo fifo0 (
        .core_clk   (core_clk),
        .sys_reset  (sys_reset),
        .push_i     (trk_push),
        .entry_i    (trk_entry),
        .pop_i      (ser_pop),
        .head_o     (fifo_head),
        .not_empty_o(fifo_not_empty),
        .overflow_o (overflow_o)
    );

    frame_serializer serializer0 (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .head_i      (fifo_head),
        .not_empty_i (fifo_not_empty),
        .stall_i     (stall_i),
        .pop_o       (ser_pop),
        .byte_o      (byte_o),
        .byte_valid_o(byte_valid_o)
    );
endmodule

/* bench/frame_streamer_props.sv */
module frame_streamer_props (
    input logic core_clk,
    input logic sys_reset,
    input logic stall_i,
    input logic byte_valid_i,
    input logic overflow_i
);

    ////////////////////////////////////////
    // back-pressure

    // no byte leaves while downstream stalls
    stall_blocks_bytes: assert property (
        @(posedge core_clk) disable iff (sys_reset)
        stall_i |-> !byte_valid_i
    ) else $error("byte_valid_o was high in a stalled cycle");

    ////////////////////////////////////////
    // reset values

    // one cycle after a reset edge both outputs are quiet
    reset_clears_outputs: assert property (
        @(posedge core_clk)
        sys_reset |=> (!byte_valid_i && !overflow_i)
    ) else $error("byte_valid_o or overflow_o not low after reset");

    // overflow is sticky, only a reset clears it
    overflow_sticky: assert property (
        @(posedge core_clk)
        $fell(overflow_i) |-> $past(sys_reset)
    ) else $error("overflow_o fell without a reset");

endmodule

bind frame_streamer frame_streamer_props props0 (
    .core_clk    (core_clk),
    .sys_reset   (sys_reset),
    .stall_i     (stall_i),
    .byte_valid_i(byte_valid_o),
    .overflow_i  (overflow_o)
);

/* bench/frame_streamer_tb.sv */
`include "frame_params.svh"

module frame_streamer_tb;
    localparam int MAIN_PAIRS  = 25;
    localparam int PAIR_GAP    = 5;
    localparam int MAIN_ROWS   = MAIN_PAIRS * PAIR_GAP;
    localparam int HOLD_PAIRS  = 11;
    localparam int HOLD_ROWS   = HOLD_PAIRS + 3;
    localparam int NUM_ROWS    = MAIN_ROWS + HOLD_ROWS;
    localparam int DEPTH       = 1 << `FIFO_DEPTH_LOG2;
    localparam int CYCLE_LIMIT = 20 * NUM_ROWS + 200;

    logic              core_clk;
    logic              sys_reset;
    frame_pkg::pixel_t ch0_i;
    frame_pkg::pixel_t ch1_i;
    logic              pix_valid_i;
    logic              sof_i;
    logic              stall_i;
    frame_pkg::pixel_t byte_o;
    logic              byte_valid_o;
    logic              overflow_o;

    // "BIVFRAME"
    frame_pkg::pixel_t marker [8] = '{8'h42, 8'h49, 8'h56, 8'h46, 8'h52, 8'h41, 8'h4D, 8'h45};

    // stimulus table with one row per cycle
    frame_pkg::pixel_t tbl_ch0 [NUM_ROWS];
    frame_pkg::pixel_t tbl_ch1 [NUM_ROWS];
    logic              tbl_valid [NUM_ROWS];
    logic              tbl_sof [NUM_ROWS];
    logic              tbl_stall [NUM_ROWS];

    // reference model state
    frame_pkg::pixel_t exp_q [$];
    int                model_col;
    int                model_row;
    logic              model_started;
    logic              model_hold;
    int                model_kept;

    int mismatch_errs;
    int other_errs;
    int cycles;

    frame_streamer dut0 (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .ch0_i       (ch0_i),
        .ch1_i       (ch1_i),
        .pix_valid_i (pix_valid_i),
        .sof_i       (sof_i),
        .stall_i     (stall_i),
        .byte_o      (byte_o),
        .byte_valid_o(byte_valid_o),
        .overflow_o  (overflow_o)
    );

    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    ////////////////////////////////////////
    // table and reference model

    task automatic build_table();
        int k;
        int r;
        for (r = 0; r < NUM_ROWS; r++) begin
            tbl_ch0[r]   = '0;
            tbl_ch1[r]   = '0;
            tbl_valid[r] = 1'b0;
            tbl_sof[r]   = 1'b0;
            // scattered stall in about 3 cycles of 11
            tbl_stall[r] = ((((r * 7) + 3) % 11) < 3);
        end
        // 3 pairs ahead of sof then a frame, an auto restart and a mid-frame sof
        for (k = 0; k < MAIN_PAIRS; k++) begin
            r = k * PAIR_GAP;
            tbl_ch0[r]   = frame_pkg::pixel_t'($urandom);
            tbl_ch1[r]   = frame_pkg::pixel_t'($urandom);
            tbl_valid[r] = 1'b1;
            tbl_sof[r]   = (k == 3) || (k == 20);
        end
        // back-to-back burst under a held stall
        for (k = 0; k < HOLD_PAIRS; k++) begin
            r = MAIN_ROWS + k;
            tbl_ch0[r]   = frame_pkg::pixel_t'($urandom);
            tbl_ch1[r]   = frame_pkg::pixel_t'($urandom);
            tbl_valid[r] = 1'b1;
            tbl_sof[r]   = (k == 0);
        end
        for (r = MAIN_ROWS; r < NUM_ROWS; r++) begin
            tbl_stall[r] = 1'b1;
        end
    endtask

    task automatic model_reset();
        model_col     = 0;
        model_row     = 0;
        model_started = 1'b0;
        model_kept    = 0;
    endtask

    function automatic void model_pair(input frame_pkg::pixel_t c0, input frame_pkg::pixel_t c1,
                                       input logic sof);
        logic tag;
        if (sof) begin
            model_col     = 0;
            model_row     = 0;
            model_started = 1'b1;
        end
        tag = model_started && (model_col == 0) && (model_row == 0);
        if (model_col == `FRAME_WIDTH - 1) begin
            model_col = 0;
            model_row = (model_row == `FRAME_HEIGHT - 1) ? 0 : model_row + 1;
        end else begin
            model_col = model_col + 1;
        end
        // a never-popping serializer leaves room for DEPTH pairs only
        if (model_hold) begin
            if (model_kept >= DEPTH) begin
                return;
            end
            model_kept = model_kept + 1;
        end
        if (!model_started) begin
            return;
        end
        if (tag) begin
            for (int i = 0; i < 8; i++) begin
                exp_q.push_back(marker[i]);
            end
        end
        exp_q.push_back(c0);
        exp_q.push_back(c1);
    endfunction

    ////////////////////////////////////////
    // drive, drain and report

    task automatic apply_rows(input int lo, input int hi);
        int r;
        for (r = lo; r < hi; r++) begin
            @(posedge core_clk);
            ch0_i       <= tbl_ch0[r];
            ch1_i       <= tbl_ch1[r];
            pix_valid_i <= tbl_valid[r];
            sof_i       <= tbl_sof[r];
            stall_i     <= tbl_stall[r];
            if (tbl_valid[r]) begin
                model_pair(tbl_ch0[r], tbl_ch1[r], tbl_sof[r]);
            end
        end
        @(posedge core_clk);
        pix_valid_i <= 1'b0;
        sof_i       <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge core_clk);
        end
        // room for any surplus byte to show up
        repeat (20) @(posedge core_clk);
    endtask

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other failures", mismatch_errs, other_errs);
    endtask

    // byte monitor sampled mid-cycle
    always @(negedge core_clk) begin
        frame_pkg::pixel_t exp_byte;
        if (!sys_reset && byte_valid_o === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                $display("byte %h came out when no more bytes were expected", byte_o);
                other_errs++;
            end
            if (exp_q.size() > 0) begin
                exp_byte = exp_q.pop_front();
                assert (byte_o === exp_byte) else begin
                    $display("CHECK FAILED byte_o: got %h, expected %h", byte_o, exp_byte);
                    mismatch_errs++;
                end
            end
        end
    end

    always @(posedge core_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the byte stream did not drain within %0d cycles", CYCLE_LIMIT);
            other_errs++;
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        void'($urandom(77769));
        sys_reset     = 1'b1;
        ch0_i         = '0;
        ch1_i         = '0;
        pix_valid_i   = 1'b0;
        sof_i         = 1'b0;
        stall_i       = 1'b0;
        mismatch_errs = 0;
        other_errs    = 0;
        cycles        = 0;
        model_hold    = 1'b0;
        build_table();
        model_reset();

        repeat (8) @(posedge core_clk);
        sys_reset <= 1'b0;

        // paced pairs with scattered stalls
        apply_rows(0, MAIN_ROWS);
        stall_i <= 1'b0;
        wait_drain();
        @(negedge core_clk);
        assert (overflow_o === 1'b0) else begin
            $display("CHECK FAILED overflow_o: got %h, expected %h", overflow_o, 1'b0);
            mismatch_errs++;
        end

        // fresh reset and then a fill past the FIFO depth
        @(posedge core_clk);
        sys_reset <= 1'b1;
        stall_i   <= 1'b1;
        repeat (8) @(posedge core_clk);
        sys_reset <= 1'b0;
        model_reset();
        model_hold = 1'b1;
        apply_rows(MAIN_ROWS, NUM_ROWS);
        @(negedge core_clk);
        assert (overflow_o === 1'b1) else begin
            $display("CHECK FAILED overflow_o: got %h, expected %h", overflow_o, 1'b1);
            mismatch_errs++;
        end
        @(posedge core_clk);
        stall_i <= 1'b0;
        wait_drain();
        // the flag outlives the drain
        @(negedge core_clk);
        assert (overflow_o === 1'b1) else begin
            $display("CHECK FAILED overflow_o: got %h, expected %h", overflow_o, 1'b1);
            mismatch_errs++;
        end

        // only a reset brings the raised flag back down
        @(posedge core_clk);
        sys_reset <= 1'b1;
        repeat (8) @(posedge core_clk);
        sys_reset <= 1'b0;
        @(negedge core_clk);
        assert (overflow_o === 1'b0) else begin
            $display("CHECK FAILED overflow_o: got %h, expected %h", overflow_o, 1'b0);
            mismatch_errs++;
        end

        report_counts();
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end
endmodule

/* frame_streamer.f */
+incdir+include
source/frame_pkg.sv
source/pixel_position_tracker.sv
source/pair_fifo.sv
source/frame_serializer.sv
source/frame_streamer.sv
bench/frame_streamer_props.sv
bench/frame_streamer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the frame_streamer testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
status=0

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module frame_streamer_tb \
    -f frame_streamer.f \
    -o frame_streamer_sim

./obj_dir/frame_streamer_sim > "$LOG" 2>&1 || status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    exit 1
fi
exit 0
